//--- design/rv_pkg.sv
package rv_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int xlen  = 64;
  localparam int ilen  = 32;
  localparam int imm_w = 12;

  localparam int dmem_depth_default = 256;  // doublewords

  typedef logic [xlen-1:0]  xlen_t;      // register or data word
  typedef logic [ilen-1:0]  instr_t;     // raw instruction
  typedef logic [4:0]       reg_addr_t;  // register index
  typedef logic [imm_w-1:0] imm_t;       // raw 12-bit immediate

  // --------------------
  // encodings
  // --------------------
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_slt
  } alu_op_t;

  typedef enum logic [6:0] {
    op_reg   = 7'b0110011,  // R-type alu
    op_imm   = 7'b0010011,  // I-type alu
    op_load  = 7'b0000011,
    op_store = 7'b0100011
  } opcode_t;

  // --------------------
  // stage registers
  // --------------------
  typedef struct packed {
    logic      valid;
    alu_op_t   alu_op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    xlen_t     rs1_data;    // register file value, not yet forwarded
    xlen_t     rs2_data;
    xlen_t     imm_ext;     // sign extended I or S immediate
    logic      use_imm;     // second operand is the immediate
    logic      reg_wr;      // writes rd, never set for rd 0
    logic      mem_rd;
    logic      mem_wr;
  } dec_stage_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    logic      reg_wr;
    logic      mem_rd;
    logic      mem_wr;
    xlen_t     result;      // alu result or memory address
    xlen_t     store_data;
  } exe_stage_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    xlen_t     data;
  } wb_t;

endpackage

//--- design/rv_reg_file.sv
module rv_reg_file (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::xlen_t     rs1_data,
  output rv_pkg::xlen_t     rs2_data,
  input  rv_pkg::wb_t       wr
);

  rv_pkg::xlen_t regs [32];

  // x0 reads zero, a same-cycle write is seen before the stored value
  function automatic rv_pkg::xlen_t read_port(
    input rv_pkg::reg_addr_t addr,
    input rv_pkg::wb_t       wr_port,
    input rv_pkg::xlen_t     stored
  );
    if (addr == '0) return '0;
    if (wr_port.valid && wr_port.rd == addr) return wr_port.data;  // write-first bypass
    return stored;
  endfunction

  assign rs1_data = read_port(rs1, wr, regs[rs1]);
  assign rs2_data = read_port(rs2, wr, regs[rs2]);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.valid && wr.rd != '0) begin
      regs[wr.rd] <= wr.data;
    end
  end

endmodule

//--- design/rv_decode.sv
module rv_decode (
  input  logic               clk,
  input  logic               rst,
  input  logic               instr_valid,
  input  rv_pkg::instr_t     instr,
  output rv_pkg::reg_addr_t  rs1,
  output rv_pkg::reg_addr_t  rs2,
  input  rv_pkg::xlen_t      rs1_data,
  input  rv_pkg::xlen_t      rs2_data,
  output rv_pkg::dec_stage_t dec
);

  rv_pkg::opcode_t    opcode;
  logic [2:0]         funct3;
  logic               funct7_alt;  // instr[30], picks sub over add
  rv_pkg::reg_addr_t  rd;
  rv_pkg::imm_t       imm_i;
  rv_pkg::imm_t       imm_s;
  logic               legal;
  rv_pkg::dec_stage_t dec_next;

  // --------------------
  // field split
  // --------------------
  assign opcode     = rv_pkg::opcode_t'(instr[6:0]);
  assign rd         = instr[11:7];
  assign funct3     = instr[14:12];
  assign rs1        = instr[19:15];
  assign rs2        = instr[24:20];
  assign funct7_alt = instr[30];
  assign imm_i      = instr[31:20];
  assign imm_s      = {instr[31:25], instr[11:7]};

  always_comb begin
    legal             = 1'b0;
    dec_next          = '0;
    dec_next.alu_op   = rv_pkg::alu_add;  // also the address adder for ld/sd
    dec_next.rd       = rd;
    dec_next.rs1      = rs1;
    dec_next.rs2      = rs2;
    dec_next.rs1_data = rs1_data;
    dec_next.rs2_data = rs2_data;
    dec_next.imm_ext  = {{(rv_pkg::xlen - rv_pkg::imm_w){imm_i[rv_pkg::imm_w-1]}}, imm_i};

    case (opcode)
      rv_pkg::op_reg: begin
        legal           = 1'b1;
        dec_next.reg_wr = (rd != '0);
        case (funct3)
          3'b000:  dec_next.alu_op = funct7_alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
          3'b001:  dec_next.alu_op = rv_pkg::alu_sll;
          3'b010:  dec_next.alu_op = rv_pkg::alu_slt;
          3'b100:  dec_next.alu_op = rv_pkg::alu_xor;
          3'b101:  dec_next.alu_op = rv_pkg::alu_srl;
          3'b110:  dec_next.alu_op = rv_pkg::alu_or;
          3'b111:  dec_next.alu_op = rv_pkg::alu_and;
          default: legal = 1'b0;  // sltu not supported
        endcase
      end
      rv_pkg::op_imm: begin
        legal            = 1'b1;
        dec_next.use_imm = 1'b1;
        dec_next.reg_wr  = (rd != '0);
        case (funct3)
          3'b000:  dec_next.alu_op = rv_pkg::alu_add;
          3'b100:  dec_next.alu_op = rv_pkg::alu_xor;
          3'b110:  dec_next.alu_op = rv_pkg::alu_or;
          3'b111:  dec_next.alu_op = rv_pkg::alu_and;
          default: legal = 1'b0;
        endcase
      end
      rv_pkg::op_load: begin
        legal            = (funct3 == 3'b011);  // ld only
        dec_next.use_imm = 1'b1;
        dec_next.mem_rd  = 1'b1;
        dec_next.reg_wr  = (rd != '0);
      end
      rv_pkg::op_store: begin
        legal            = (funct3 == 3'b011);  // sd only
        dec_next.use_imm = 1'b1;
        dec_next.mem_wr  = 1'b1;
        dec_next.imm_ext = {{(rv_pkg::xlen - rv_pkg::imm_w){imm_s[rv_pkg::imm_w-1]}}, imm_s};
      end
      default: legal = 1'b0;
    endcase

    dec_next.valid = instr_valid & legal;
    if (!dec_next.valid) begin
      // bubble carries no side effects
      dec_next.reg_wr = 1'b0;
      dec_next.mem_rd = 1'b0;
      dec_next.mem_wr = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec <= '0;
    end else begin
      dec <= dec_next;
    end
  end

endmodule

//--- design/rv_execute.sv
module rv_execute (
  input  logic               clk,
  input  logic               rst,
  input  rv_pkg::dec_stage_t dec,
  input  rv_pkg::wb_t        fwd_result,  // instruction one ahead, final value
  input  rv_pkg::wb_t        wb,          // instruction two ahead
  output rv_pkg::exe_stage_t exe
);

  rv_pkg::xlen_t      op_a;
  rv_pkg::xlen_t      rs2_fwd;
  rv_pkg::xlen_t      op_b;
  rv_pkg::xlen_t      alu_out;
  logic [5:0]         shamt;
  rv_pkg::exe_stage_t exe_next;

  // youngest producer first, then register file value
  function automatic rv_pkg::xlen_t fwd_operand(
    input rv_pkg::reg_addr_t src,
    input rv_pkg::xlen_t     rf_value,
    input rv_pkg::wb_t       younger,
    input rv_pkg::wb_t       older
  );
    if (src != '0 && younger.valid && younger.rd == src) return younger.data;
    if (src != '0 && older.valid && older.rd == src) return older.data;
    return rf_value;
  endfunction

  // --------------------
  // operand select
  // --------------------
  assign op_a    = fwd_operand(dec.rs1, dec.rs1_data, fwd_result, wb);
  assign rs2_fwd = fwd_operand(dec.rs2, dec.rs2_data, fwd_result, wb);
  assign op_b    = dec.use_imm ? dec.imm_ext : rs2_fwd;
  assign shamt   = op_b[5:0];

  // --------------------
  // alu
  // --------------------
  always_comb begin
    case (dec.alu_op)
      rv_pkg::alu_add: alu_out = op_a + op_b;
      rv_pkg::alu_sub: alu_out = op_a - op_b;
      rv_pkg::alu_and: alu_out = op_a & op_b;
      rv_pkg::alu_or:  alu_out = op_a | op_b;
      rv_pkg::alu_xor: alu_out = op_a ^ op_b;
      rv_pkg::alu_sll: alu_out = op_a << shamt;
      rv_pkg::alu_srl: alu_out = op_a >> shamt;
      rv_pkg::alu_slt: alu_out = {{(rv_pkg::xlen - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default:         alu_out = '0;
    endcase
  end

  always_comb begin
    exe_next.valid      = dec.valid;
    exe_next.rd         = dec.rd;
    exe_next.reg_wr     = dec.reg_wr;
    exe_next.mem_rd     = dec.mem_rd;
    exe_next.mem_wr     = dec.mem_wr;
    exe_next.result     = alu_out;
    exe_next.store_data = rs2_fwd;  // sd data, forwarded like any source
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      exe <= '0;
    end else begin
      exe <= exe_next;
    end
  end

endmodule

//--- design/rv_data_mem.sv
module rv_data_mem #(
  parameter int dmem_depth = rv_pkg::dmem_depth_default
) (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::xlen_t addr,
  input  logic          wr_en,
  input  rv_pkg::xlen_t wr_data,
  output rv_pkg::xlen_t rd_data
);

  localparam int idx_w = $clog2(dmem_depth);

  rv_pkg::xlen_t    mem [dmem_depth];
  logic [idx_w-1:0] idx;

  // byte address, low 3 bits dropped, wraps at dmem_depth
  assign idx     = addr[3 +: idx_w];
  assign rd_data = mem[idx];  // async read

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < dmem_depth; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[idx] <= wr_data;
    end
  end

endmodule

//--- design/rv_result.sv
module rv_result #(
  parameter int dmem_depth = rv_pkg::dmem_depth_default
) (
  input  logic               clk,
  input  logic               rst,
  input  rv_pkg::exe_stage_t exe,
  output rv_pkg::wb_t        fwd_result,
  output rv_pkg::wb_t        wb
);

  rv_pkg::xlen_t load_data;
  logic          store_en;

  // --------------------
  // memory access
  // --------------------
  assign store_en = exe.valid & exe.mem_wr;

  rv_data_mem #(
    .dmem_depth (dmem_depth)
  ) rv_data_mem_inst (
    .clk     (clk),
    .rst     (rst),
    .addr    (exe.result),
    .wr_en   (store_en),
    .wr_data (exe.store_data),
    .rd_data (load_data)
  );

  // final value of the instruction in exe, also the forwarding source
  always_comb begin
    fwd_result.valid = exe.valid & exe.reg_wr;
    fwd_result.rd    = exe.rd;
    fwd_result.data  = exe.mem_rd ? load_data : exe.result;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb <= '0;
    end else begin
      wb <= fwd_result;
    end
  end

endmodule

//--- design/rv_datapath.sv
module rv_datapath #(
  parameter int dmem_depth = rv_pkg::dmem_depth_default
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           instr_valid,
  input  rv_pkg::instr_t instr,
  output rv_pkg::wb_t    wb
);

  rv_pkg::reg_addr_t  rs1;
  rv_pkg::reg_addr_t  rs2;
  rv_pkg::xlen_t      rs1_data;
  rv_pkg::xlen_t      rs2_data;
  rv_pkg::dec_stage_t dec;
  rv_pkg::exe_stage_t exe;
  rv_pkg::wb_t        fwd_result;

  rv_reg_file rv_reg_file_inst (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr       (wb)  // write port is the writeback register
  );

  rv_decode rv_decode_inst (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rs1         (rs1),
    .rs2         (rs2),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .dec         (dec)
  );

  rv_execute rv_execute_inst (
    .clk        (clk),
    .rst        (rst),
    .dec        (dec),
    .fwd_result (fwd_result),
    .wb         (wb),
    .exe        (exe)
  );

  rv_result #(
    .dmem_depth (dmem_depth)
  ) rv_result_inst (
    .clk        (clk),
    .rst        (rst),
    .exe        (exe),
    .fwd_result (fwd_result),
    .wb         (wb)
  );

endmodule

//--- verification/tb_rv_datapath.sv
module tb_rv_datapath;

  localparam int dmem_depth     = 16;   // small memory so addresses alias quickly
  localparam int n_random       = 300;
  localparam int max_gap        = 3;
  localparam int timeout_cycles = n_random * (max_gap + 1) + 400;  // random mix plus directed

  logic           clk = 1'b0;
  logic           rst;
  logic           instr_valid;
  rv_pkg::instr_t instr;
  rv_pkg::wb_t    wb;

  logic [63:0] model_regs [32];
  logic [63:0] model_mem [dmem_depth];
  rv_pkg::wb_t exp_q [$];  // predicted register writes, program order
  rv_pkg::wb_t exp_wb;
  logic [31:0] lfsr;
  int          cycle_count = 0;

  rv_datapath #(
    .dmem_depth (dmem_depth)
  ) rv_datapath_inst (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb          (wb)
  );

  always #20 clk = ~clk;

  // --------------------
  // encoders
  // --------------------
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return enc_i(7'b0010011, 3'b000, rd, rs1, imm);
  endfunction

  function automatic logic [31:0] ld(input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [11:0] imm);
    return enc_i(7'b0000011, 3'b011, rd, rs1, imm);
  endfunction

  function automatic logic [31:0] sd(input logic [4:0] rs2, input logic [4:0] rs1,
                                     input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
  endfunction

  // galois lfsr, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // --------------------
  // reference model
  // --------------------
  function automatic int word_index(input logic [63:0] addr);
    logic [63:0] word;
    word = (addr >> 3) % 64'(dmem_depth);  // byte address to doubleword slot
    return int'(word);
  endfunction

  function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [63:0] a, input logic [63:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[5:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      3'b100:  return a ^ b;
      3'b101:  return a >> b[5:0];
      3'b110:  return a | b;
      3'b111:  return a & b;
      default: return '0;
    endcase
  endfunction

  function automatic void model_apply(input logic [31:0] i);
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] res;
    logic        writes;
    rv_pkg::wb_t e;
    rd     = i[11:7];
    f3     = i[14:12];
    a      = model_regs[i[19:15]];
    b      = model_regs[i[24:20]];
    imm_i  = {{52{i[31]}}, i[31:20]};
    imm_s  = {{52{i[31]}}, i[31:25], i[11:7]};
    res    = '0;
    writes = 1'b0;
    case (i[6:0])
      7'b0110011: begin
        writes = (f3 != 3'b011);  // no sltu
        res    = alu_ref(f3, i[30], a, b);
      end
      7'b0010011: begin
        writes = (f3 == 3'b000 || f3 == 3'b100 || f3 == 3'b110 || f3 == 3'b111);
        res    = alu_ref(f3, 1'b0, a, imm_i);
      end
      7'b0000011: begin
        writes = (f3 == 3'b011);
        res    = model_mem[word_index(a + imm_i)];
      end
      7'b0100011: begin
        if (f3 == 3'b011) model_mem[word_index(a + imm_s)] = b;
      end
      default: writes = 1'b0;
    endcase
    if (writes && rd != 5'd0) begin
      model_regs[rd] = res;
      e.valid        = 1'b1;
      e.rd           = rd;
      e.data         = res;
      exp_q.push_back(e);
    end
  endfunction

  // --------------------
  // checking
  // --------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] expected);
    if (got !== expected) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected);
      abort_run("write-back value mismatch");
    end
  endtask

  always @(negedge clk) begin
    if (!rst && wb.valid) begin
      if (exp_q.size() == 0) begin
        abort_run("write-back pulse seen with no register write expected");
      end else begin
        exp_wb = exp_q.pop_front();
        check_eq("wb.rd", 64'(wb.rd), 64'(exp_wb.rd));
        check_eq("wb.data", wb.data, exp_wb.data);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) abort_run("timeout, cycle limit reached");
  end

  // --------------------
  // drivers
  // --------------------
  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      instr_valid = 1'b0;
      instr       = '0;
    end
  endtask

  task automatic issue(input logic [31:0] i, input int gap);
    @(negedge clk);
    instr_valid = 1'b1;
    instr       = i;
    model_apply(i);
    idle(gap);
  endtask

  // wait for pending writes, then a few more cycles to catch stray pulses
  task automatic drain();
    int waited;
    waited = 1;
    idle(1);
    while (exp_q.size() != 0) begin
      if (waited >= 10) abort_run("register writes still pending 10 cycles after last issue");
      idle(1);
      waited++;
    end
    idle(4);
  endtask

  // --------------------
  // tests
  // --------------------
  task automatic alu_ops_test();
    issue(addi(5'd1, 5'd0, 12'h123), 4);
    issue(addi(5'd2, 5'd0, 12'hffb), 4);  // -5
    issue(addi(5'd3, 5'd0, 12'h800), 4);  // -2048
    issue(enc_i(7'b0010011, 3'b100, 5'd4, 5'd1, 12'hfff), 4);  // xori -1
    issue(enc_i(7'b0010011, 3'b110, 5'd5, 5'd2, 12'h0f0), 4);
    issue(enc_i(7'b0010011, 3'b111, 5'd6, 5'd3, 12'h7ff), 4);
    issue(enc_r(7'h00, 3'b000, 5'd7, 5'd1, 5'd2), 4);
    issue(enc_r(7'h20, 3'b000, 5'd8, 5'd1, 5'd2), 4);
    issue(enc_r(7'h00, 3'b111, 5'd9, 5'd1, 5'd2), 4);
    issue(enc_r(7'h00, 3'b110, 5'd10, 5'd1, 5'd2), 4);
    issue(enc_r(7'h00, 3'b100, 5'd11, 5'd1, 5'd2), 4);
    issue(enc_r(7'h00, 3'b001, 5'd12, 5'd1, 5'd1), 4);  // shift by 35
    issue(enc_r(7'h00, 3'b101, 5'd13, 5'd2, 5'd1), 4);  // logical, negative source
    issue(enc_r(7'h00, 3'b010, 5'd14, 5'd2, 5'd1), 4);
    issue(enc_r(7'h00, 3'b010, 5'd15, 5'd1, 5'd2), 4);
    issue(enc_r(7'h00, 3'b010, 5'd16, 5'd3, 5'd2), 4);
    drain();
  endtask

  task automatic forwarding_test();
    issue(addi(5'd20, 5'd0, 12'd7), 0);
    issue(addi(5'd21, 5'd20, 12'd1), 1);               // exe stage source
    issue(enc_r(7'h00, 3'b000, 5'd22, 5'd21, 5'd20), 2);  // writeback stage source
    issue(enc_r(7'h20, 3'b000, 5'd23, 5'd22, 5'd0), 0);   // register file bypass
    issue(addi(5'd24, 5'd0, 12'd5), 0);
    issue(addi(5'd24, 5'd0, 12'd9), 0);
    issue(enc_r(7'h00, 3'b000, 5'd25, 5'd24, 5'd24), 0);  // youngest x24 wins
    issue(addi(5'd24, 5'd24, 12'hfff), 0);
    issue(enc_r(7'h00, 3'b100, 5'd26, 5'd24, 5'd25), 0);
    issue(sd(5'd26, 5'd0, 12'h008), 0);                   // forwarded store data
    issue(ld(5'd27, 5'd0, 12'h008), 0);
    drain();
  endtask

  task automatic load_store_test();
    issue(addi(5'd1, 5'd0, 12'h040), 0);
    issue(addi(5'd2, 5'd0, 12'hfb3), 0);  // -77
    issue(sd(5'd2, 5'd1, 12'h000), 0);
    issue(ld(5'd3, 5'd1, 12'h000), 0);
    issue(enc_r(7'h00, 3'b000, 5'd4, 5'd3, 5'd3), 0);  // load result used next cycle
    issue(ld(5'd5, 5'd1, 12'h085), 0);                 // wraps and has low bits set
    issue(sd(5'd4, 5'd1, 12'hff8), 0);
    issue(ld(5'd6, 5'd1, 12'h07f), 0);
    issue(ld(5'd7, 5'd0, 12'h010), 0);                 // never written
    drain();
  endtask

  task automatic no_writeback_test();
    issue(addi(5'd1, 5'd0, 12'h055), 0);
    issue(addi(5'd0, 5'd1, 12'd5), 0);
    issue(enc_r(7'h00, 3'b000, 5'd0, 5'd1, 5'd1), 0);
    issue(enc_r(7'h00, 3'b110, 5'd8, 5'd0, 5'd0), 0);  // x0 must read zero
    issue(sd(5'd1, 5'd0, 12'h025), 0);                 // rd field is x5
    issue({20'hfffff, 5'd1, 7'b1111111}, 0);           // unknown opcode
    issue(enc_r(7'h00, 3'b011, 5'd1, 5'd1, 5'd1), 0);  // sltu, not supported
    issue(enc_r(7'h00, 3'b000, 5'd9, 5'd1, 5'd0), 0);
    issue(ld(5'd0, 5'd0, 12'h020), 0);
    drain();
  endtask

  task automatic random_mix_test();
    logic [2:0]  kind;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        alt;
    logic [31:0] i;
    int          gap;
    for (int n = 0; n < n_random; n++) begin
      kind = 3'(rand_bits(3));
      f3   = 3'(rand_bits(3));
      rd   = 5'(rand_bits(3));  // x0..x7
      rs1  = 5'(rand_bits(3));
      rs2  = 5'(rand_bits(3));
      alt  = 1'(rand_bits(1));
      case (kind)
        3'd0, 3'd1, 3'd2: i = enc_r((f3 == 3'b000 && alt) ? 7'h20 : 7'h00, f3, rd, rs1, rs2);
        3'd3, 3'd4:       i = enc_i(7'b0010011, f3, rd, rs1, 12'(rand_bits(12)));
        3'd5:             i = ld(rd, 5'd0, 12'(rand_bits(7)));
        default:          i = sd(rs2, 5'd0, 12'(rand_bits(7)));
      endcase
      gap = int'(rand_bits(2));
      issue(i, gap);
    end
    drain();
  endtask

  initial begin
    lfsr        = 32'h54789a41;
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    for (int m = 0; m < dmem_depth; m++) begin
      model_mem[m] = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    alu_ops_test();
    forwarding_test();
    load_store_test();
    no_writeback_test();
    random_mix_test();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- flist.f
design/rv_pkg.sv
design/rv_reg_file.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_data_mem.sv
design/rv_result.sv
design/rv_datapath.sv
verification/tb_rv_datapath.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench, exit status follows the simulation result
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module tb_rv_datapath -o sim_rv_datapath

./obj_dir/sim_rv_datapath
